// File: src/i2c_pkg.sv
package i2c_pkg;

  ////////////////////////////////////////////////////////////
  // frame sequencing
  ////////////////////////////////////////////////////////////

  // one state per frame section
  // every section except idle spends two scl phases per bit
  typedef enum logic [3:0] {
    st_idle,
    st_start,
    st_addr,
    st_rw,
    st_ack,
    st_write,
    st_read,
    st_ack2,
    st_stop
  } i2c_state_e;

  ////////////////////////////////////////////////////////////
  // per-master configuration and frame outcome
  ////////////////////////////////////////////////////////////

  // what one master sends on its next frame
  typedef struct packed {
    logic [6:0] addr;
    // 1 = read
    logic       rw;
    // only used on writes
    logic [7:0] wdata;
  } master_cfg_t;

  // snapshot taken at stop
  typedef struct packed {
    logic [6:0] addr;
    logic       rw;
    // byte written, or byte read back
    logic [7:0] data;
    // slave-owned ack slot saw a 1
    logic       nack;
  } frame_result_t;

endpackage

// File: src/disp_pkg.sv
package disp_pkg;

  ////////////////////////////////////////////////////////////
  // seven-segment display types
  ////////////////////////////////////////////////////////////

  // scan order, left digit first
  // the encoding doubles as the scan counter
  typedef enum logic [1:0] {
    // top 3 address bits
    dig_addr_hi,
    // low address nibble
    dig_addr_lo,
    dig_data_hi,
    dig_data_lo
  } digit_e;

  // segment lines in gfedcba order
  // active low, a 0 lights the segment
  typedef logic [6:0] seg_t;

endpackage

// File: src/master_config.sv
`timescale 1ns/1ps

module master_config
  import i2c_pkg::*;
(
  input  logic        clk,
  input  logic        reset,
  input  logic        cfg_we,
  input  logic        cfg_sel,
  input  master_cfg_t cfg_word,
  input  logic        go,
  output master_cfg_t cfg0,
  output master_cfg_t cfg1,
  output logic [1:0]  start
);

  ////////////////////////////////////////////////////////////
  // power-up frames
  ////////////////////////////////////////////////////////////

  // master 0 writes 6f to 55
  localparam master_cfg_t CFG0_INIT = '{addr: 7'h55, rw: 1'b0, wdata: 8'h6f};
  // master 1 writes 8f to 47
  localparam master_cfg_t CFG1_INIT = '{addr: 7'h47, rw: 1'b0, wdata: 8'h8f};

  ////////////////////////////////////////////////////////////
  // config registers and start strobes
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (reset) begin
      cfg0  <= CFG0_INIT;
      cfg1  <= CFG1_INIT;
      start <= 2'b00;
    end else begin
      // cfg_sel picks the target register
      if (cfg_we) begin
        if (cfg_sel) begin
          cfg1 <= cfg_word;
        end else begin
          cfg0 <= cfg_word;
        end
      end
      // one-hot start, one cycle after go
      // a write in the same cycle is already visible with the pulse
      start <= {go & cfg_sel, go & ~cfg_sel};
    end
  end

endmodule

// File: src/i2c_frame_master.sv
`timescale 1ns/1ps

module i2c_frame_master
  import i2c_pkg::*;
(
  input  logic          clk,
  input  logic          reset,
  input  logic          grant,
  input  logic          start,
  input  master_cfg_t   cfg,
  input  logic          sda_in,
  output logic          scl,
  output logic          sda,
  output logic          busy,
  output logic          done,
  output frame_result_t result
);

  i2c_state_e  state;
  // 0 = scl low half, 1 = scl high half
  logic        phase;
  logic [2:0]  bit_cnt;
  // tx bits leave from bit 7, rx bits enter at bit 0
  logic [7:0]  shift_q;
  logic        nack;
  master_cfg_t cfg_q;
  logic        accept;
  logic        step;

  // start only lands in idle
  assign accept = (state == st_idle) && start;
  // any non-idle cycle with grant moves one half slot
  assign step   = grant && (state != st_idle);

  ////////////////////////////////////////////////////////////
  // frame FSM, scl and sda
  ////////////////////////////////////////////////////////////

  // state, phase, scl and sda always describe the same half slot
  // each step computes the next half slot and its line levels
  always_ff @(posedge clk) begin
    if (reset) begin
      state   <= st_idle;
      phase   <= 1'b0;
      bit_cnt <= 3'd0;
      scl     <= 1'b1;
      sda     <= 1'b1;
      busy    <= 1'b0;
      done    <= 1'b0;
      nack    <= 1'b0;
    end else begin
      done <= 1'b0;
      if (accept) begin
        busy  <= 1'b1;
        nack  <= 1'b0;
        state <= st_start;
        // idle already shows the first start half (scl 1, sda 1)
        // so a granted accept goes straight to sda low
        phase <= grant;
        sda   <= ~grant;
      end else if (step) begin
        if (!phase) begin
          // low half to high half
          phase <= 1'b1;
          scl   <= 1'b1;
          // start condition, sda falls with scl high
          if (state == st_start) begin
            sda <= 1'b0;
          end
        end else begin
          // high half to the next slot, scl drops by default
          phase <= 1'b0;
          scl   <= 1'b0;
          case (state)
            st_start: begin
              state   <= st_addr;
              bit_cnt <= 3'd6;
              sda     <= shift_q[7];
            end
            st_addr: begin
              // after a0 the next bit out is r/w
              sda <= shift_q[6];
              if (bit_cnt == 3'd0) begin
                state <= st_rw;
              end else begin
                bit_cnt <= bit_cnt - 3'd1;
              end
            end
            st_rw: begin
              // release for the slave ack
              state <= st_ack;
              sda   <= 1'b1;
            end
            st_ack: begin
              nack    <= nack | sda_in;
              bit_cnt <= 3'd7;
              if (cfg_q.rw) begin
                state <= st_read;
                sda   <= 1'b1;
              end else begin
                state <= st_write;
                sda   <= cfg_q.wdata[7];
              end
            end
            st_write: begin
              if (bit_cnt == 3'd0) begin
                state <= st_ack2;
                sda   <= 1'b1;
              end else begin
                bit_cnt <= bit_cnt - 3'd1;
                sda     <= shift_q[6];
              end
            end
            st_read: begin
              // slave owns sda for the whole byte
              sda <= 1'b1;
              if (bit_cnt == 3'd0) begin
                state <= st_ack2;
              end else begin
                bit_cnt <= bit_cnt - 3'd1;
              end
            end
            st_ack2: begin
              // on reads this slot is our own nack, not checked
              if (!cfg_q.rw) begin
                nack <= nack | sda_in;
              end
              state <= st_stop;
              sda   <= 1'b0;
            end
            st_stop: begin
              // stop condition, sda rises with scl high
              state <= st_idle;
              scl   <= 1'b1;
              sda   <= 1'b1;
              busy  <= 1'b0;
              done  <= 1'b1;
            end
            default: begin
              state <= st_idle;
              scl   <= 1'b1;
              sda   <= 1'b1;
            end
          endcase
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////
  // payload, shift register and result
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (accept) begin
      cfg_q   <= cfg;
      // address and r/w go out as one 8-bit run
      shift_q <= {cfg.addr, cfg.rw};
    end else if (step && phase) begin
      case (state)
        st_addr, st_write, st_read: begin
          // sample on the high half
          shift_q <= {shift_q[6:0], sda_in};
        end
        st_ack: begin
          if (!cfg_q.rw) begin
            shift_q <= cfg_q.wdata;
          end
        end
        st_stop: begin
          result.addr <= cfg_q.addr;
          result.rw   <= cfg_q.rw;
          result.data <= cfg_q.rw ? shift_q : cfg_q.wdata;
          result.nack <= nack;
        end
        default: begin
          shift_q <= shift_q;
        end
      endcase
    end
  end

endmodule

// File: src/hex_display_scan.sv
`timescale 1ns/1ps

module hex_display_scan
  import i2c_pkg::*;
  import disp_pkg::*;
#(
  parameter int DIGIT_HOLD = 16
) (
  input  logic          clk,
  input  logic          reset,
  input  logic [1:0]    done,
  input  frame_result_t result0,
  input  frame_result_t result1,
  output frame_result_t last_result,
  output logic [3:0]    anode,
  output seg_t          cathode
);

  localparam int HOLD_W = $clog2(DIGIT_HOLD);

  logic [HOLD_W-1:0] hold_cnt;
  digit_e            digit;
  logic [3:0]        nibble;

  ////////////////////////////////////////////////////////////
  // hex to segment table
  ////////////////////////////////////////////////////////////

  function automatic seg_t hex_to_seg(input logic [3:0] value);
    seg_t seg;
    case (value)
      4'h0: seg = 7'b1000000;
      4'h1: seg = 7'b1111001;
      4'h2: seg = 7'b0100100;
      4'h3: seg = 7'b0110000;
      4'h4: seg = 7'b0011001;
      4'h5: seg = 7'b0010010;
      4'h6: seg = 7'b0000010;
      4'h7: seg = 7'b1111000;
      4'h8: seg = 7'b0000000;
      4'h9: seg = 7'b0010000;
      4'ha: seg = 7'b0001000;
      // lower case b and d
      4'hb: seg = 7'b0000011;
      4'hc: seg = 7'b1000110;
      4'hd: seg = 7'b0100001;
      4'he: seg = 7'b0000110;
      default: seg = 7'b0001110;
    endcase
    return seg;
  endfunction

  ////////////////////////////////////////////////////////////
  // result latch
  ////////////////////////////////////////////////////////////

  // only the granted master can finish, so the two never collide
  always_ff @(posedge clk) begin
    if (reset) begin
      last_result <= '0;
    end else if (done[0]) begin
      last_result <= result0;
    end else if (done[1]) begin
      last_result <= result1;
    end
  end

  ////////////////////////////////////////////////////////////
  // digit scan
  ////////////////////////////////////////////////////////////

  // each digit stays lit for DIGIT_HOLD cycles
  always_ff @(posedge clk) begin
    if (reset) begin
      hold_cnt <= '0;
      digit    <= dig_addr_hi;
    end else if (hold_cnt == HOLD_W'(DIGIT_HOLD - 1)) begin
      hold_cnt <= '0;
      // wraps from data_lo back to addr_hi
      digit    <= digit_e'(digit + 2'd1);
    end else begin
      hold_cnt <= hold_cnt + 1'b1;
    end
  end

  // anode select and nibble mux
  always_comb begin
    case (digit)
      dig_addr_hi: begin
        anode  = 4'b0111;
        // 7-bit address, top digit only 0..7
        nibble = {1'b0, last_result.addr[6:4]};
      end
      dig_addr_lo: begin
        anode  = 4'b1011;
        nibble = last_result.addr[3:0];
      end
      dig_data_hi: begin
        anode  = 4'b1101;
        nibble = last_result.data[7:4];
      end
      default: begin
        anode  = 4'b1110;
        nibble = last_result.data[3:0];
      end
    endcase
  end

  assign cathode = hex_to_seg(nibble);

endmodule

// File: src/i2c_dual_master_top.sv
`timescale 1ns/1ps

module i2c_dual_master_top
  import i2c_pkg::*;
  import disp_pkg::*;
#(
  parameter int DIGIT_HOLD = 16
) (
  input  logic          clk,
  input  logic          reset,
  input  logic          arb_control,
  input  logic          cfg_we,
  input  logic          cfg_sel,
  input  master_cfg_t   cfg_word,
  input  logic          go,
  input  logic [1:0]    sda_in,
  output logic [1:0]    scl,
  output logic [1:0]    sda,
  output logic [1:0]    busy,
  output frame_result_t last_result,
  output logic [3:0]    anode,
  output seg_t          cathode
);

  master_cfg_t   cfg0;
  master_cfg_t   cfg1;
  logic [1:0]    start;
  logic [1:0]    done;
  frame_result_t result0;
  frame_result_t result1;

  ////////////////////////////////////////////////////////////
  // config and start strobes
  ////////////////////////////////////////////////////////////

  master_config u_config (
    .clk      (clk),
    .reset    (reset),
    .cfg_we   (cfg_we),
    .cfg_sel  (cfg_sel),
    .cfg_word (cfg_word),
    .go       (go),
    .cfg0     (cfg0),
    .cfg1     (cfg1),
    .start    (start)
  );

  ////////////////////////////////////////////////////////////
  // masters, arb_control low grants master 0
  ////////////////////////////////////////////////////////////

  i2c_frame_master u_master0 (
    .clk    (clk),
    .reset  (reset),
    .grant  (~arb_control),
    .start  (start[0]),
    .cfg    (cfg0),
    .sda_in (sda_in[0]),
    .scl    (scl[0]),
    .sda    (sda[0]),
    .busy   (busy[0]),
    .done   (done[0]),
    .result (result0)
  );

  i2c_frame_master u_master1 (
    .clk    (clk),
    .reset  (reset),
    .grant  (arb_control),
    .start  (start[1]),
    .cfg    (cfg1),
    .sda_in (sda_in[1]),
    .scl    (scl[1]),
    .sda    (sda[1]),
    .busy   (busy[1]),
    .done   (done[1]),
    .result (result1)
  );

  // last finished frame on the 4-digit display
  hex_display_scan #(
    .DIGIT_HOLD (DIGIT_HOLD)
  ) u_display (
    .clk         (clk),
    .reset       (reset),
    .done        (done),
    .result0     (result0),
    .result1     (result1),
    .last_result (last_result),
    .anode       (anode),
    .cathode     (cathode)
  );

endmodule

// File: tb/i2c_dual_master_assert.sv
`timescale 1ns/1ps

module i2c_dual_master_assert
  import i2c_pkg::*;
(
  input logic       clk,
  input logic       reset,
  input logic       grant,
  input logic       scl,
  input logic       sda,
  input logic       done,
  input i2c_state_e state,
  input logic [3:0] anode
);

  // failures seen by this instance
  int err_cnt = 0;

  // lines frozen while the other master owns the bus
  a_frozen: assert property (@(posedge clk) disable iff (reset)
    !grant |=> $stable(scl) && $stable(sda))
    else begin
      $error("scl or sda changed without grant");
      err_cnt++;
    end

  // done is a single pulse
  a_done_pulse: assert property (@(posedge clk) disable iff (reset) done |=> !done)
    else begin
      $error("done held for more than one cycle");
      err_cnt++;
    end

  // sda moves under a high scl only for start and stop
  a_sda_edges: assert property (@(posedge clk) disable iff (reset)
    scl && $past(scl) && $changed(sda) |-> state inside {st_start, st_idle})
    else begin
      $error("sda changed while scl was high outside start or stop");
      err_cnt++;
    end

  // one digit lit at a time
  a_one_digit: assert property (@(posedge clk) disable iff (reset) $onehot(~anode))
    else begin
      $error("anode not one-hot low");
      err_cnt++;
    end

endmodule

// master instances with the anode check tied off
bind i2c_frame_master i2c_dual_master_assert u_frame_assert (
  .clk (clk), .reset (reset), .grant (grant), .scl (scl), .sda (sda),
  .done (done), .state (state), .anode (4'b1110)
);

// display instance with the bus checks tied off
bind hex_display_scan i2c_dual_master_assert u_scan_assert (
  .clk (clk), .reset (reset), .grant (1'b1), .scl (1'b1), .sda (1'b1),
  .done (1'b0), .state (st_idle), .anode (anode)
);

// File: tb/tb_i2c_dual_master.sv
`timescale 1ns/1ps

module tb_i2c_dual_master
  import i2c_pkg::*;
  import disp_pkg::*;
();

  localparam int DIGIT_HOLD = 16;
  // 4 writes, 3 reads, 2 unknown, 3 pairs
  localparam int NUM_FRAMES = 15;
  localparam int TIMEOUT = NUM_FRAMES * 40 * 4 + NUM_FRAMES * 20 + 5 + 8 * DIGIT_HOLD + 200;

  logic          clk;
  logic          reset;
  logic          arb_control;
  logic          cfg_we;
  logic          cfg_sel;
  master_cfg_t   cfg_word;
  logic          go;
  logic [1:0]    sda_in;
  logic [1:0]    scl;
  logic [1:0]    sda;
  logic [1:0]    busy;
  frame_result_t last_result;
  logic [3:0]    anode;
  seg_t          cathode;

  integer seed;
  int     pass_cnt;
  int     fail_cnt;
  int     err_cnt;
  int     cycle_cnt;

  // slave model state per master
  logic [1:0] prev_scl;
  logic [1:0] prev_sda;
  int         bit_idx   [2];
  logic       in_frame  [2];
  logic [6:0] s_addr    [2];
  logic       s_rw      [2];
  logic [7:0] s_data    [2];
  logic [7:0] s_rbyte   [2];
  logic       s_ack2    [2];
  int         stop_cnt  [2];

  // addresses the slaves answer
  logic [6:0] known_addr [6] = '{7'h55, 7'h47, 7'h1a, 7'h3c, 7'h62, 7'h0b};

  // active low patterns in gfedcba order
  seg_t seg_table [16] = '{
    7'h40, 7'h79, 7'h24, 7'h30, 7'h19, 7'h12, 7'h02, 7'h78,
    7'h00, 7'h10, 7'h08, 7'h03, 7'h46, 7'h21, 7'h06, 7'h0e
  };

  i2c_dual_master_top #(
    .DIGIT_HOLD (DIGIT_HOLD)
  ) u_i2c_dual_master (
    .clk         (clk),
    .reset       (reset),
    .arb_control (arb_control),
    .cfg_we      (cfg_we),
    .cfg_sel     (cfg_sel),
    .cfg_word    (cfg_word),
    .go          (go),
    .sda_in      (sda_in),
    .scl         (scl),
    .sda         (sda),
    .busy        (busy),
    .last_result (last_result),
    .anode       (anode),
    .cathode     (cathode)
  );

  always #2 clk = ~clk;

  ////////////////////////////////////////////////////////////
  // helpers
  ////////////////////////////////////////////////////////////

  function automatic bit is_known(input logic [6:0] addr);
    bit hit;
    hit = 1'b0;
    foreach (known_addr[k]) begin
      if (known_addr[k] == addr) hit = 1'b1;
    end
    return hit;
  endfunction

  // level the slave puts on sda_in for slot idx
  function automatic logic slave_bit(input int m, input int idx);
    logic v;
    v = 1'b1;
    if (idx == 8) begin
      v = !is_known(s_addr[m]);
    end else if (idx >= 9 && idx <= 16 && s_rw[m]) begin
      v = s_rbyte[m][16 - idx];
    end else if (idx == 17 && !s_rw[m]) begin
      v = !is_known(s_addr[m]);
    end
    return v;
  endfunction

  task automatic check(input string name, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (expected !== actual) begin
      $display("[FAIL] t=%0t %s expected %0h got %0h", $time, name, expected, actual);
      err_cnt++;
    end
  endtask

  task automatic end_test(input string name);
    if (err_cnt == 0) begin
      pass_cnt++;
      $display("test %s: pass", name);
    end else begin
      fail_cnt++;
      $display("test %s: %0d errors", name, err_cnt);
    end
    err_cnt = 0;
  endtask

  function automatic frame_result_t expect_result(input int m, input master_cfg_t c);
    frame_result_t r;
    r.addr = c.addr;
    r.rw   = c.rw;
    r.data = c.rw ? s_rbyte[m] : c.wdata;
    r.nack = !is_known(c.addr);
    return r;
  endfunction

  ////////////////////////////////////////////////////////////
  // slave models decoding on scl edges
  ////////////////////////////////////////////////////////////

  always @(posedge clk) begin
    if (reset) begin
      prev_scl <= 2'b11;
      prev_sda <= 2'b11;
      sda_in   <= 2'b11;
      for (int i = 0; i < 2; i++) begin
        in_frame[i] <= 1'b0;
        stop_cnt[i] <= 0;
      end
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (prev_scl[i] && scl[i] && prev_sda[i] && !sda[i]) begin
          // start condition
          bit_idx[i]  <= 0;
          in_frame[i] <= 1'b1;
          s_rbyte[i]  <= 8'($random(seed));
          sda_in[i]   <= 1'b1;
        end else if (prev_scl[i] && scl[i] && !prev_sda[i] && sda[i]) begin
          // stop condition
          if (in_frame[i]) stop_cnt[i] <= stop_cnt[i] + 1;
          in_frame[i] <= 1'b0;
          sda_in[i]   <= 1'b1;
        end else if (!prev_scl[i] && scl[i] && in_frame[i]) begin
          // rising scl samples one bit
          if (bit_idx[i] < 7) s_addr[i] <= {s_addr[i][5:0], sda[i]};
          if (bit_idx[i] == 7) s_rw[i] <= sda[i];
          if (bit_idx[i] >= 9 && bit_idx[i] <= 16) s_data[i] <= {s_data[i][6:0], sda[i]};
          if (bit_idx[i] == 17) s_ack2[i] <= sda[i];
          bit_idx[i] <= bit_idx[i] + 1;
        end else if (prev_scl[i] && !scl[i] && in_frame[i]) begin
          // falling scl sets up the next slot
          sda_in[i] <= slave_bit(i, bit_idx[i]);
        end
      end
      prev_scl <= scl;
      prev_sda <= sda;
    end
  end

  // run limit
  always @(posedge clk) begin
    cycle_cnt++;
    if (cycle_cnt >= TIMEOUT) begin
      $display("timeout: run did not finish within %0d cycles", TIMEOUT);
      $display("Something failed");
      $finish;
    end
  end

  ////////////////////////////////////////////////////////////
  // frame tasks
  ////////////////////////////////////////////////////////////

  // one frame on a held grant
  task automatic run_frame(input int m, input master_cfg_t c);
    frame_result_t exp_r;
    int            lat;
    int            stops;
    stops = stop_cnt[m];
    @(posedge clk);
    cfg_we      <= 1'b1;
    cfg_sel     <= m[0];
    cfg_word    <= c;
    go          <= 1'b1;
    arb_control <= m[0];
    @(posedge clk);
    cfg_we <= 1'b0;
    go     <= 1'b0;
    while (!u_i2c_dual_master.start[m]) @(posedge clk);
    lat = 0;
    do begin
      @(posedge clk);
      lat++;
      // busy spans the frame and drops together with done
      check("busy", lat < 40, busy[m]);
    end while (!u_i2c_dual_master.done[m] && lat < 200);
    if (lat >= 200) begin
      $display("master %0d never finished its frame", m);
      err_cnt++;
    end
    check("done latency", 40, lat);
    @(posedge clk);
    exp_r = expect_result(m, c);
    check("last_result", exp_r, last_result);
    check("slave addr", c.addr, s_addr[m]);
    check("slave rw", c.rw, s_rw[m]);
    // released lines read as ones on a read
    check("slave data", c.rw ? 8'hff : c.wdata, s_data[m]);
    if (c.rw) check("ack2 sda", 1'b1, s_ack2[m]);
    check("stop count", stops + 1, stop_cnt[m]);
  endtask

  // both masters on a randomly toggled grant
  task automatic interleave_frames(input master_cfg_t c0, input master_cfg_t c1);
    frame_result_t exp_r   [2];
    logic [1:0]    last_scl;
    logic [1:0]    last_sda;
    logic          last_arb;
    int            finished;
    int            pending;
    int            n;
    finished = 0;
    pending  = -1;
    n        = 0;
    @(posedge clk);
    cfg_we   <= 1'b1;
    cfg_sel  <= 1'b0;
    cfg_word <= c0;
    go       <= 1'b1;
    @(posedge clk);
    cfg_sel  <= 1'b1;
    cfg_word <= c1;
    @(posedge clk);
    cfg_we <= 1'b0;
    go     <= 1'b0;
    last_scl = scl;
    last_sda = sda;
    last_arb = arb_control;
    while (finished < 2 && n < 1000) begin
      @(posedge clk);
      n++;
      // master without grant must not move
      if (last_arb) begin
        check("scl0 frozen", last_scl[0], scl[0]);
        check("sda0 frozen", last_sda[0], sda[0]);
      end else begin
        check("scl1 frozen", last_scl[1], scl[1]);
        check("sda1 frozen", last_sda[1], sda[1]);
      end
      if (pending >= 0) begin
        check("last_result order", exp_r[pending], last_result);
        pending = -1;
      end
      for (int i = 0; i < 2; i++) begin
        if (u_i2c_dual_master.done[i]) begin
          exp_r[i] = expect_result(i, i ? c1 : c0);
          pending  = i;
          finished++;
        end
      end
      last_scl = scl;
      last_sda = sda;
      last_arb = arb_control;
      arb_control <= $random(seed);
    end
    if (finished < 2) begin
      $display("pair of frames did not complete");
      err_cnt++;
    end
    @(posedge clk);
    if (pending >= 0) check("last_result order", exp_r[pending], last_result);
  endtask

  function automatic master_cfg_t rand_cfg(input bit rw, input bit known);
    master_cfg_t c;
    c.rw    = rw;
    c.wdata = 8'($random(seed));
    if (known) begin
      c.addr = known_addr[$unsigned($random(seed)) % 6];
    end else begin
      do c.addr = 7'($random(seed)); while (is_known(c.addr));
    end
    return c;
  endfunction

  ////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////

  initial begin
    logic [3:0] nib;
    logic [3:0] seen;
    int         assert_errs;
    seed        = 32'hb27;
    pass_cnt    = 0;
    fail_cnt    = 0;
    err_cnt     = 0;
    cycle_cnt   = 0;
    clk         = 1'b0;
    reset       = 1'b1;
    arb_control = 1'b0;
    cfg_we      = 1'b0;
    cfg_sel     = 1'b0;
    cfg_word    = '0;
    go          = 1'b0;
    sda_in      = 2'b11;
    repeat (5) @(posedge clk);
    reset <= 1'b0;
    @(posedge clk);

    // reset values
    check("scl", 2'b11, scl);
    check("sda", 2'b11, sda);
    check("busy", 2'b00, busy);
    check("last_result", 0, last_result);
    check("anode", 4'b0111, anode);
    check("cathode", seg_table[0], cathode);
    end_test("reset");

    for (int k = 0; k < 4; k++) run_frame(k % 2, rand_cfg(1'b0, 1'b1));
    end_test("write frames");
    for (int k = 0; k < 3; k++) run_frame(k % 2, rand_cfg(1'b1, 1'b1));
    end_test("read frames");
    run_frame(0, rand_cfg(1'b0, 1'b0));
    run_frame(1, rand_cfg(1'b1, 1'b0));
    end_test("unknown address");
    for (int k = 0; k < 3; k++) begin
      interleave_frames(rand_cfg(k[0], 1'b1), rand_cfg(1'b0, k != 1));
    end
    end_test("arbitration");

    // digit scan over one full round
    seen = 4'b0000;
    repeat (4 * DIGIT_HOLD) begin
      @(posedge clk);
      case (anode)
        4'b0111: nib = {1'b0, last_result.addr[6:4]};
        4'b1011: nib = last_result.addr[3:0];
        4'b1101: nib = last_result.data[7:4];
        default: nib = last_result.data[3:0];
      endcase
      seen = seen | ~anode;
      check("cathode", seg_table[nib], cathode);
    end
    check("digits seen", 4'b1111, seen);
    end_test("display");

    // failures flagged by the bound assertions
    assert_errs = u_i2c_dual_master.u_master0.u_frame_assert.err_cnt
                + u_i2c_dual_master.u_master1.u_frame_assert.err_cnt
                + u_i2c_dual_master.u_display.u_scan_assert.err_cnt;
    if (assert_errs != 0) begin
      $display("bound assertions failed %0d times during the run", assert_errs);
      err_cnt += assert_errs;
    end
    end_test("assertions");

    $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
    if (fail_cnt == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: i2c_dual_master.f
src/i2c_pkg.sv
src/disp_pkg.sv
src/master_config.sv
src/i2c_frame_master.sv
src/hex_display_scan.sv
src/i2c_dual_master_top.sv
tb/i2c_dual_master_assert.sv
tb/tb_i2c_dual_master.sv
